// File: logic/debug_command.sv
module debug_command (
    input  logic             i_clk_5mhz,
    input  logic             i_reset_n,
    input  logic             i_spi_cs_n,
    input  debug_pkg::byte_t i_rx_byte,
    input  logic             i_rx_valid,
    output debug_pkg::byte_t o_tx_byte,
    output logic             o_tx_valid,
    output debug_pkg::word_t o_mem_addr,
    output logic             o_mem_en,
    output logic             o_mem_we,
    output debug_pkg::byte_t o_mem_wdata,
    input  debug_pkg::byte_t i_mem_rdata,
    output debug_pkg::word_t o_val_id,
    output logic             o_val_en,
    output logic             o_val_we,
    output debug_pkg::word_t o_val_wdata,
    input  debug_pkg::word_t i_val_rdata
);

    debug_pkg::cmd_e  r_cmd;
    logic [2:0]       r_pos;          // Byte position in the frame, saturates at 5
    debug_pkg::byte_t r_op_hi;        // Operand high byte from b1
    debug_pkg::word_t r_addr;         // Running address or value id
    debug_pkg::byte_t r_wr_hi;
    debug_pkg::byte_t r_rd_lo;
    logic             r_resp_valid;
    logic             r_resp_mem;     // Response comes from memory read data
    debug_pkg::byte_t r_resp_byte;
    logic             w_accept;
    logic             w_is_mem;
    debug_pkg::word_t w_operand;
    debug_pkg::word_t w_target;
    logic             w_mem_rd;
    logic             w_mem_wr;
    logic             w_val_rd;
    logic             w_val_wr;

    assign w_accept  = i_rx_valid & ~i_spi_cs_n;
    assign w_operand = {r_op_hi, i_rx_byte};
    assign w_is_mem  = (r_cmd == debug_pkg::CMD_MEM_READ) || (r_cmd == debug_pkg::CMD_MEM_WRITE);

    // Accesses happen in the cycle the byte arrives
    assign w_mem_rd = w_accept && (r_cmd == debug_pkg::CMD_MEM_READ) && (r_pos >= 3'd2);
    assign w_mem_wr = w_accept && (r_cmd == debug_pkg::CMD_MEM_WRITE) && (r_pos >= 3'd3);
    assign w_val_rd = w_accept && (r_cmd == debug_pkg::CMD_VALUE_READ) && (r_pos == 3'd2);
    assign w_val_wr = w_accept && (r_cmd == debug_pkg::CMD_VALUE_WRITE) && (r_pos == 3'd4);

    // At b2 the operand is still arriving, so take it straight from the byte
    assign w_target = (r_pos == 3'd2) ? w_operand : r_addr;

    assign o_mem_addr  = w_target;
    assign o_mem_en    = w_mem_rd | w_mem_wr;
    assign o_mem_we    = w_mem_wr;
    assign o_mem_wdata = i_rx_byte;

    assign o_val_id    = w_target;
    assign o_val_en    = w_val_rd | w_val_wr;
    assign o_val_we    = w_val_wr;
    assign o_val_wdata = {r_wr_hi, i_rx_byte};

    always_ff @(posedge i_clk_5mhz or negedge i_reset_n)
    begin
        if (!i_reset_n)
        begin
            r_cmd        <= debug_pkg::cmd_e'(8'h00);
            r_pos        <= '0;
            r_op_hi      <= '0;
            r_addr       <= '0;
            r_wr_hi      <= '0;
            r_rd_lo      <= '0;
            r_resp_valid <= 1'b0;
            r_resp_mem   <= 1'b0;
            r_resp_byte  <= '0;
            o_tx_byte    <= '0;
            o_tx_valid   <= 1'b0;
        end
        else if (i_spi_cs_n)
        begin
            // Frame ended or aborted
            r_pos        <= '0;
            r_resp_valid <= 1'b0;
            r_resp_mem   <= 1'b0;
            o_tx_valid   <= 1'b0;
        end
        else
        begin
            // Second stage, hand the response byte to the SPI block
            o_tx_valid <= r_resp_valid;
            if (r_resp_valid)
            begin
                o_tx_byte <= r_resp_mem ? i_mem_rdata : r_resp_byte;
            end

            r_resp_valid <= w_accept;
            if (w_accept)
            begin
                r_resp_mem  <= w_mem_rd;
                r_resp_byte <= 8'h00;
                if (r_pos != 3'd5)
                begin
                    r_pos <= r_pos + 3'd1;
                end

                if (r_pos == 3'd0)
                begin
                    r_cmd <= debug_pkg::cmd_e'(i_rx_byte);   // Unknown codes kept as is
                end
                if (r_pos == 3'd1)
                begin
                    r_op_hi <= i_rx_byte;
                end

                if (r_pos == 3'd2)
                begin
                    // Read has already issued the first access
                    r_addr <= (r_cmd == debug_pkg::CMD_MEM_READ) ? w_operand + 16'd1 : w_operand;
                end
                else if (w_is_mem && (r_pos >= 3'd3))
                begin
                    r_addr <= r_addr + 16'd1;   // Wraps in memory through low bits
                end

                if (w_val_rd)
                begin
                    r_resp_byte <= i_val_rdata[15:8];
                    r_rd_lo     <= i_val_rdata[7:0];
                end
                if ((r_pos == 3'd3) && (r_cmd == debug_pkg::CMD_VALUE_READ))
                begin
                    r_resp_byte <= r_rd_lo;
                end
                if ((r_pos == 3'd3) && (r_cmd == debug_pkg::CMD_VALUE_WRITE))
                begin
                    r_wr_hi <= i_rx_byte;
                end
            end
        end
    end

endmodule

// File: logic/debug_memory.sv
module debug_memory (
    input  logic             i_clk_5mhz,
    input  logic             i_a_en,
    input  logic             i_a_we,
    input  debug_pkg::word_t i_a_addr,
    input  debug_pkg::byte_t i_a_wdata,
    output debug_pkg::byte_t o_a_rdata,
    input  logic             i_b_en,
    input  debug_pkg::word_t i_b_addr,
    output debug_pkg::byte_t o_b_rdata
);

    debug_pkg::byte_t r_mem [0:debug_pkg::MEM_DEPTH-1];

    // Port A, command engine read and write
    always_ff @(posedge i_clk_5mhz)
    begin
        if (i_a_en)
        begin
            if (i_a_we)
            begin
                r_mem[i_a_addr[debug_pkg::MEM_ADDR_BITS-1:0]] <= i_a_wdata;
            end
            o_a_rdata <= r_mem[i_a_addr[debug_pkg::MEM_ADDR_BITS-1:0]];   // Old data on write
        end
    end

    // Port B, instruction fetch
    always_ff @(posedge i_clk_5mhz)
    begin
        if (i_b_en)
        begin
            o_b_rdata <= r_mem[i_b_addr[debug_pkg::MEM_ADDR_BITS-1:0]];
        end
    end

endmodule

// File: logic/debug_pkg.sv
package debug_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] word_t;

    // Command codes, sent as the first byte of a frame
    typedef enum logic [7:0]
    {
        CMD_MEM_READ    = 8'h01,
        CMD_MEM_WRITE   = 8'h02,
        CMD_VALUE_READ  = 8'h03,
        CMD_VALUE_WRITE = 8'h04
    } cmd_e;

    // Debug value identifiers
    typedef enum logic [15:0]
    {
        VAL_STEP       = 16'd0,   // Write bit 0 to step, read bit 0 as busy
        VAL_PC         = 16'd1,
        VAL_IR         = 16'd2,   // Read only
        VAL_STEP_COUNT = 16'd3,   // Read only
        VAL_RESET_HOLD = 16'd4
    } value_id_e;

    // Memory sizing
    localparam int MEM_ADDR_BITS = 12;
    localparam int MEM_DEPTH     = 1 << MEM_ADDR_BITS;

    // Program counter after reset and while held
    localparam word_t RESET_PC = 16'h0000;

endpackage

// File: logic/debug_values.sv
module debug_values (
    input  logic             i_clk_5mhz,
    input  logic             i_reset_n,
    input  logic             i_en,
    input  logic             i_we,
    input  debug_pkg::word_t i_id,
    input  debug_pkg::word_t i_wdata,
    output debug_pkg::word_t o_rdata,
    output logic             o_step,
    output logic             o_pc_load,
    output debug_pkg::word_t o_pc_value,
    output logic             o_hold,
    input  logic             i_busy,
    input  debug_pkg::word_t i_pc,
    input  debug_pkg::byte_t i_ir,
    input  debug_pkg::word_t i_step_count
);

    logic w_write;

    assign w_write = i_en & i_we;

    // Writes become strobes to the sequencer
    always_ff @(posedge i_clk_5mhz or negedge i_reset_n)
    begin
        if (!i_reset_n)
        begin
            o_step     <= 1'b0;
            o_pc_load  <= 1'b0;
            o_pc_value <= '0;
            o_hold     <= 1'b0;
        end
        else
        begin
            o_step    <= w_write && (i_id == debug_pkg::VAL_STEP) && i_wdata[0];
            o_pc_load <= w_write && (i_id == debug_pkg::VAL_PC);
            if (w_write && (i_id == debug_pkg::VAL_PC))
            begin
                o_pc_value <= i_wdata;
            end
            if (w_write && (i_id == debug_pkg::VAL_RESET_HOLD))
            begin
                o_hold <= i_wdata[0];
            end
        end
    end

    // Live read-back of sequencer state
    always_comb
    begin
        case (i_id)
            debug_pkg::VAL_STEP:       o_rdata = {15'd0, i_busy};
            debug_pkg::VAL_PC:         o_rdata = i_pc;
            debug_pkg::VAL_IR:         o_rdata = {8'h00, i_ir};
            debug_pkg::VAL_STEP_COUNT: o_rdata = i_step_count;
            debug_pkg::VAL_RESET_HOLD: o_rdata = {15'd0, o_hold};
            default:                   o_rdata = '0;   // Unknown ids read as zero
        endcase
    end

endmodule

// File: logic/debugger_top.sv
module debugger_top (
    input  logic i_clk_5mhz,
    input  logic i_reset_n,
    input  logic i_spi_cs_n,
    input  logic i_spi_clk,
    input  logic i_spi_copi,
    output logic o_spi_cipo
);

    debug_pkg::byte_t w_rx_byte;
    logic             w_rx_valid;
    debug_pkg::byte_t w_tx_byte;
    logic             w_tx_valid;

    debug_pkg::word_t w_mem_addr;
    logic             w_mem_en;
    logic             w_mem_we;
    debug_pkg::byte_t w_mem_wdata;
    debug_pkg::byte_t w_mem_rdata;

    debug_pkg::word_t w_val_id;
    logic             w_val_en;
    logic             w_val_we;
    debug_pkg::word_t w_val_wdata;
    debug_pkg::word_t w_val_rdata;

    // Value block to sequencer
    logic             w_step;
    logic             w_pc_load;
    debug_pkg::word_t w_pc_value;
    logic             w_hold;
    logic             w_busy;
    debug_pkg::word_t w_pc;
    debug_pkg::byte_t w_ir;
    debug_pkg::word_t w_step_count;

    debug_pkg::word_t w_fetch_addr;
    logic             w_fetch_en;
    debug_pkg::byte_t w_fetch_data;

    spi_peripheral u_spi_peripheral (
        .i_clk_5mhz (i_clk_5mhz),
        .i_reset_n  (i_reset_n),
        .i_spi_cs_n (i_spi_cs_n),
        .i_spi_clk  (i_spi_clk),
        .i_spi_copi (i_spi_copi),
        .o_spi_cipo (o_spi_cipo),
        .o_rx_byte  (w_rx_byte),
        .o_rx_valid (w_rx_valid),
        .i_tx_byte  (w_tx_byte),
        .i_tx_valid (w_tx_valid)
    );

    debug_command u_debug_command (
        .i_clk_5mhz  (i_clk_5mhz),
        .i_reset_n   (i_reset_n),
        .i_spi_cs_n  (i_spi_cs_n),
        .i_rx_byte   (w_rx_byte),
        .i_rx_valid  (w_rx_valid),
        .o_tx_byte   (w_tx_byte),
        .o_tx_valid  (w_tx_valid),
        .o_mem_addr  (w_mem_addr),
        .o_mem_en    (w_mem_en),
        .o_mem_we    (w_mem_we),
        .o_mem_wdata (w_mem_wdata),
        .i_mem_rdata (w_mem_rdata),
        .o_val_id    (w_val_id),
        .o_val_en    (w_val_en),
        .o_val_we    (w_val_we),
        .o_val_wdata (w_val_wdata),
        .i_val_rdata (w_val_rdata)
    );

    debug_memory u_debug_memory (
        .i_clk_5mhz (i_clk_5mhz),
        .i_a_en     (w_mem_en),
        .i_a_we     (w_mem_we),
        .i_a_addr   (w_mem_addr),
        .i_a_wdata  (w_mem_wdata),
        .o_a_rdata  (w_mem_rdata),
        .i_b_en     (w_fetch_en),
        .i_b_addr   (w_fetch_addr),
        .o_b_rdata  (w_fetch_data)
    );

    debug_values u_debug_values (
        .i_clk_5mhz   (i_clk_5mhz),
        .i_reset_n    (i_reset_n),
        .i_en         (w_val_en),
        .i_we         (w_val_we),
        .i_id         (w_val_id),
        .i_wdata      (w_val_wdata),
        .o_rdata      (w_val_rdata),
        .o_step       (w_step),
        .o_pc_load    (w_pc_load),
        .o_pc_value   (w_pc_value),
        .o_hold       (w_hold),
        .i_busy       (w_busy),
        .i_pc         (w_pc),
        .i_ir         (w_ir),
        .i_step_count (w_step_count)
    );

    fetch_sequencer u_fetch_sequencer (
        .i_clk_5mhz   (i_clk_5mhz),
        .i_reset_n    (i_reset_n),
        .i_step       (w_step),
        .i_pc_load    (w_pc_load),
        .i_pc_value   (w_pc_value),
        .i_hold       (w_hold),
        .o_busy       (w_busy),
        .o_fetch_addr (w_fetch_addr),
        .o_fetch_en   (w_fetch_en),
        .i_fetch_data (w_fetch_data),
        .o_pc         (w_pc),
        .o_ir         (w_ir),
        .o_step_count (w_step_count)
    );

endmodule

// File: logic/fetch_sequencer.sv
module fetch_sequencer (
    input  logic             i_clk_5mhz,
    input  logic             i_reset_n,
    input  logic             i_step,
    input  logic             i_pc_load,
    input  debug_pkg::word_t i_pc_value,
    input  logic             i_hold,
    output logic             o_busy,
    output debug_pkg::word_t o_fetch_addr,
    output logic             o_fetch_en,
    input  debug_pkg::byte_t i_fetch_data,
    output debug_pkg::word_t o_pc,
    output debug_pkg::byte_t o_ir,
    output debug_pkg::word_t o_step_count
);

    logic r_fetch;   // Fetch request to memory
    logic r_latch;   // Fetched byte arrives

    assign o_busy       = r_fetch | r_latch;
    assign o_fetch_en   = r_fetch;
    assign o_fetch_addr = o_pc;

    always_ff @(posedge i_clk_5mhz or negedge i_reset_n)
    begin
        if (!i_reset_n)
        begin
            r_fetch      <= 1'b0;
            r_latch      <= 1'b0;
            o_pc         <= debug_pkg::RESET_PC;
            o_ir         <= '0;
            o_step_count <= '0;
        end
        else if (i_hold)
        begin
            // Core held in reset, steps dropped
            r_fetch      <= 1'b0;
            r_latch      <= 1'b0;
            o_pc         <= debug_pkg::RESET_PC;
            o_step_count <= '0;
        end
        else
        begin
            r_fetch <= i_step & ~o_busy;
            r_latch <= r_fetch;
            if (r_latch)
            begin
                o_ir         <= i_fetch_data;
                o_pc         <= o_pc + 16'd1;
                o_step_count <= o_step_count + 16'd1;
            end
            else if (i_pc_load && !o_busy)
            begin
                o_pc <= i_pc_value;
            end
        end
    end

endmodule

// File: logic/spi_peripheral.sv
module spi_peripheral (
    input  logic             i_clk_5mhz,
    input  logic             i_reset_n,
    input  logic             i_spi_cs_n,
    input  logic             i_spi_clk,
    input  logic             i_spi_copi,
    output logic             o_spi_cipo,
    output debug_pkg::byte_t o_rx_byte,
    output logic             o_rx_valid,
    input  debug_pkg::byte_t i_tx_byte,
    input  logic             i_tx_valid
);

    logic [2:0]       r_sclk_sync;          // Two sync stages plus the previous value
    logic [1:0]       r_copi_sync;
    logic             w_sclk_rise;
    logic             w_sclk_fall;
    logic [2:0]       r_rx_count;
    debug_pkg::byte_t r_rx_shift;
    logic [2:0]       r_tx_count;
    debug_pkg::byte_t r_tx_shift;
    debug_pkg::byte_t r_tx_pending;
    logic             r_tx_pending_valid;

    always_ff @(posedge i_clk_5mhz or negedge i_reset_n)
    begin
        if (!i_reset_n)
        begin
            r_sclk_sync <= '0;
            r_copi_sync <= '0;
        end
        else
        begin
            r_sclk_sync <= {r_sclk_sync[1:0], i_spi_clk};
            r_copi_sync <= {r_copi_sync[0], i_spi_copi};
        end
    end

    assign w_sclk_rise = r_sclk_sync[1] & ~r_sclk_sync[2];
    assign w_sclk_fall = ~r_sclk_sync[1] & r_sclk_sync[2];

    // Receive side, MSB first on rising SCLK
    always_ff @(posedge i_clk_5mhz or negedge i_reset_n)
    begin
        if (!i_reset_n)
        begin
            r_rx_count <= '0;
            r_rx_shift <= '0;
            o_rx_valid <= 1'b0;
        end
        else
        begin
            o_rx_valid <= 1'b0;
            if (i_spi_cs_n)
            begin
                r_rx_count <= '0;
            end
            else if (w_sclk_rise)
            begin
                r_rx_shift <= {r_rx_shift[6:0], r_copi_sync[1]};
                r_rx_count <= r_rx_count + 3'd1;
                o_rx_valid <= (r_rx_count == 3'd7);   // Byte complete
            end
        end
    end

    assign o_rx_byte = r_rx_shift;   // Stable until the next rising edge

    // Transmit side, shifts on falling SCLK
    always_ff @(posedge i_clk_5mhz or negedge i_reset_n)
    begin
        if (!i_reset_n)
        begin
            r_tx_count         <= '0;
            r_tx_shift         <= '0;
            r_tx_pending       <= '0;
            r_tx_pending_valid <= 1'b0;
        end
        else if (i_spi_cs_n)
        begin
            r_tx_count         <= '0;
            r_tx_shift         <= '0;   // First byte of a frame is zero
            r_tx_pending_valid <= 1'b0;
        end
        else
        begin
            if (w_sclk_fall)
            begin
                r_tx_count <= r_tx_count + 3'd1;
                if (r_tx_count == 3'd7)
                begin
                    // Byte boundary, next byte goes out
                    r_tx_shift         <= r_tx_pending_valid ? r_tx_pending : 8'h00;
                    r_tx_pending_valid <= 1'b0;
                end
                else
                begin
                    r_tx_shift <= {r_tx_shift[6:0], 1'b0};
                end
            end
            if (i_tx_valid)
            begin
                r_tx_pending       <= i_tx_byte;
                r_tx_pending_valid <= 1'b1;
            end
        end
    end

    assign o_spi_cipo = ~i_spi_cs_n & r_tx_shift[7];

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the debugger testbench with Verilator and runs it
set -e

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --timescale 1ns/100ps \
    -f vlog.f --top-module tb_debugger -Mdir "$BUILD_DIR"

"./$BUILD_DIR/Vtb_debugger" > "$LOG" 2>&1
cat "$LOG"

if grep -q "Test failed" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi
echo "Simulation finished without failure"

// File: include/debug_tb_tasks.svh
`ifndef DEBUG_TB_TASKS_SVH
`define DEBUG_TB_TASKS_SVH

// One SCLK half period of 8 system clocks
task automatic half_period();
    for (int i = 0; i < 8; i++)
    begin
        @(negedge clk_5mhz);
    end
endtask

task automatic frame_start();
    spi_cs_n = 1'b0;   // First bit goes out on this edge
    half_period();
endtask

task automatic frame_end();
    half_period();
    spi_cs_n = 1'b1;
    half_period();
endtask

// Mode 0 transfer MSB first
// Fewer than 8 bits leaves the byte cut short
task automatic exchange_bits(input debug_pkg::byte_t tx, input int nbits,
                             output debug_pkg::byte_t rx);
    rx = '0;
    for (int i = 7; i > 7 - nbits; i--)
    begin
        spi_copi = tx[i];
        half_period();
        rx[i]   = spi_cipo;   // Settled since the last falling edge
        spi_clk = 1'b1;
        half_period();
        spi_clk = 1'b0;
    end
endtask

// Sends tx_bytes as one frame and collects the replies in rx_bytes
task automatic run_frame();
    debug_pkg::byte_t rx;
    rx_bytes.delete();
    frame_start();
    foreach (tx_bytes[i])
    begin
        exchange_bits(tx_bytes[i], 8, rx);
        rx_bytes.push_back(rx);
    end
    frame_end();
endtask

task automatic check_byte(input string name, input debug_pkg::byte_t expected,
                          input debug_pkg::byte_t actual);
    check_count++;
    if (actual !== expected)
    begin
        mismatch_count++;
        $display("MISMATCH at %0d ns: %s expected %02h actual %02h",
                 $time, name, expected, actual);
    end
endtask

task automatic check_word(input string name, input debug_pkg::word_t expected,
                          input debug_pkg::word_t actual);
    check_count++;
    if (actual !== expected)
    begin
        mismatch_count++;
        $display("MISMATCH at %0d ns: %s expected %04h actual %04h",
                 $time, name, expected, actual);
    end
endtask

`endif

// File: test/tb_debugger.sv
module tb_debugger;

    timeunit 1ns;
    timeprecision 100ps;

    logic clk_5mhz;
    logic reset_n;
    logic spi_cs_n;
    logic spi_clk;
    logic spi_copi;
    logic spi_cipo;

    integer seed;
    int     check_count;
    int     mismatch_count;
    int     timeout_count;

    debug_pkg::byte_t tx_bytes[$];
    debug_pkg::byte_t rx_bytes[$];

    // Reference model of memory and sequencer state
    debug_pkg::byte_t model_mem [0:debug_pkg::MEM_DEPTH-1];
    debug_pkg::word_t model_pc;
    debug_pkg::word_t model_count;
    debug_pkg::byte_t model_ir;
    logic             model_hold;

    debugger_top u_debugger_top (
        .i_clk_5mhz (clk_5mhz),
        .i_reset_n  (reset_n),
        .i_spi_cs_n (spi_cs_n),
        .i_spi_clk  (spi_clk),
        .i_spi_copi (spi_copi),
        .o_spi_cipo (spi_cipo)
    );

    `include "debug_tb_tasks.svh"

    initial
    begin
        clk_5mhz = 1'b0;
        forever #100 clk_5mhz = ~clk_5mhz;
    end

    function automatic debug_pkg::byte_t rand_byte();
        logic [31:0] r;
        r = $random(seed);
        return r[7:0];
    endfunction

    function automatic debug_pkg::word_t rand_word();
        logic [31:0] r;
        r = $random(seed);
        return r[15:0];
    endfunction

    function automatic int rand_range(input int n);
        logic [31:0] r;
        int          v;
        r = $random(seed);
        v = int'(r[15:0]);
        return v % n;
    endfunction

    // Expected read-back of a debug value between frames
    function automatic debug_pkg::word_t model_value(input debug_pkg::word_t id);
        if (id == debug_pkg::VAL_PC)
            return model_pc;
        if (id == debug_pkg::VAL_IR)
            return {8'h00, model_ir};
        if (id == debug_pkg::VAL_STEP_COUNT)
            return model_count;
        if (id == debug_pkg::VAL_RESET_HOLD)
            return {15'd0, model_hold};
        return 16'h0000;   // Idle step status and unknown ids
    endfunction

    task automatic push_header(input debug_pkg::byte_t cmd, input debug_pkg::word_t operand);
        tx_bytes.delete();
        tx_bytes.push_back(cmd);
        tx_bytes.push_back(operand[15:8]);
        tx_bytes.push_back(operand[7:0]);
    endtask

    task automatic check_zero_replies(input int first, input int last);
        for (int i = first; i <= last; i++)
        begin
            check_byte($sformatf("o_spi_cipo byte %0d", i), 8'h00, rx_bytes[i]);
        end
    endtask

    task automatic mem_write(input debug_pkg::word_t addr, input int len);
        logic [debug_pkg::MEM_ADDR_BITS-1:0] idx;
        debug_pkg::byte_t                    data;
        push_header(debug_pkg::CMD_MEM_WRITE, addr);
        idx = addr[debug_pkg::MEM_ADDR_BITS-1:0];
        for (int i = 0; i < len; i++)
        begin
            data = rand_byte();
            tx_bytes.push_back(data);
            model_mem[idx] = data;
            idx            = idx + 12'd1;   // Wraps at the top of memory
        end
        run_frame();
        check_zero_replies(0, rx_bytes.size() - 1);
    endtask

    task automatic mem_read(input debug_pkg::word_t addr, input int len);
        logic [debug_pkg::MEM_ADDR_BITS-1:0] idx;
        push_header(debug_pkg::CMD_MEM_READ, addr);
        for (int i = 0; i < len; i++)
        begin
            tx_bytes.push_back(rand_byte());   // Don't care bytes
        end
        run_frame();
        check_zero_replies(0, 2);
        idx = addr[debug_pkg::MEM_ADDR_BITS-1:0];
        for (int i = 0; i < len; i++)
        begin
            check_byte($sformatf("o_spi_cipo mem[%03h]", idx), model_mem[idx], rx_bytes[3 + i]);
            idx = idx + 12'd1;
        end
    endtask

    task automatic value_write(input debug_pkg::word_t id, input debug_pkg::word_t data);
        push_header(debug_pkg::CMD_VALUE_WRITE, id);
        tx_bytes.push_back(data[15:8]);
        tx_bytes.push_back(data[7:0]);
        run_frame();
        check_zero_replies(0, 4);
        if (id == debug_pkg::VAL_STEP && data[0] && !model_hold)
        begin
            model_ir    = model_mem[model_pc[debug_pkg::MEM_ADDR_BITS-1:0]];
            model_pc    = model_pc + 16'd1;
            model_count = model_count + 16'd1;
        end
        else if (id == debug_pkg::VAL_PC && !model_hold)
        begin
            model_pc = data;
        end
        else if (id == debug_pkg::VAL_RESET_HOLD)
        begin
            model_hold = data[0];
            if (model_hold)
            begin
                model_pc    = debug_pkg::RESET_PC;
                model_count = 16'd0;
            end
        end
    endtask

    task automatic value_read(input debug_pkg::word_t id, output debug_pkg::word_t data);
        push_header(debug_pkg::CMD_VALUE_READ, id);
        tx_bytes.push_back(8'h00);
        tx_bytes.push_back(8'h00);
        run_frame();
        check_zero_replies(0, 2);
        data = {rx_bytes[3], rx_bytes[4]};
    endtask

    task automatic check_value(input debug_pkg::word_t id);
        debug_pkg::word_t data;
        value_read(id, data);
        check_word($sformatf("value id %04h", id), model_value(id), data);
    endtask

    // Polls the busy bit until the step has finished
    task automatic wait_step_done();
        debug_pkg::word_t data;
        logic             busy;
        int               tries;
        busy  = 1'b1;
        tries = 0;
        while (busy && tries < 8)
        begin
            value_read(debug_pkg::VAL_STEP, data);
            busy = data[0];
            tries++;
        end
        if (busy)
        begin
            timeout_count++;
            $display("Timeout: sequencer still busy after %0d status reads", tries);
        end
    endtask

    task automatic step_and_check(input debug_pkg::word_t data);
        value_write(debug_pkg::VAL_STEP, data);
        wait_step_done();
        check_value(debug_pkg::VAL_IR);
        check_value(debug_pkg::VAL_PC);
        check_value(debug_pkg::VAL_STEP_COUNT);
    endtask

    // Sends the queued bytes then raises cs_n partway through one more byte
    task automatic aborted_frame(input int nbits);
        debug_pkg::byte_t rx;
        frame_start();
        foreach (tx_bytes[i])
        begin
            exchange_bits(tx_bytes[i], 8, rx);
        end
        exchange_bits(rand_byte(), nbits, rx);
        spi_cs_n = 1'b1;
        half_period();
    endtask

    initial
    begin
        debug_pkg::word_t addr;
        debug_pkg::byte_t code;
        int               len;

        seed           = 32'h0dc01c83;
        check_count    = 0;
        mismatch_count = 0;
        timeout_count  = 0;
        reset_n        = 1'b0;
        spi_cs_n       = 1'b1;
        spi_clk        = 1'b0;
        spi_copi       = 1'b0;
        model_pc       = debug_pkg::RESET_PC;
        model_count    = 16'd0;
        model_ir       = 8'h00;
        model_hold     = 1'b0;
        repeat (5)
        begin
            @(negedge clk_5mhz);
        end
        reset_n = 1'b1;
        half_period();

        mem_write(rand_word(), debug_pkg::MEM_DEPTH);   // Known data everywhere

        // Every other burst wraps past the top address
        for (int i = 0; i < 8; i++)
        begin
            addr = rand_word();
            len  = 1 + rand_range(24);
            if (i % 2 == 0)
            begin
                addr[11:4] = 8'hff;
                len        = 17 + rand_range(8);
            end
            mem_write(addr, len);
            mem_read(addr, len);
            mem_read(rand_word(), 1 + rand_range(24));
        end

        for (int i = 0; i < 4; i++)
        begin
            value_write(debug_pkg::VAL_PC, rand_word());
            addr = 16'd5 + 16'(rand_range(4000));   // Unknown id
            value_write(addr, rand_word());
            check_value(addr);
            check_value(debug_pkg::VAL_PC);
        end
        value_write(debug_pkg::VAL_IR, rand_word());   // Read only
        check_value(debug_pkg::VAL_IR);
        code = rand_byte();
        if (code >= 8'h01 && code <= 8'h04)
            code = code | 8'h80;
        push_header(code, rand_word());
        tx_bytes.push_back(rand_byte());
        tx_bytes.push_back(rand_byte());
        run_frame();
        check_zero_replies(0, 4);

        // Single steps from a random start
        value_write(debug_pkg::VAL_PC, rand_word());
        for (int i = 0; i < 16; i++)
        begin
            step_and_check(rand_word());
        end

        value_write(debug_pkg::VAL_RESET_HOLD, 16'h0001);
        check_value(debug_pkg::VAL_RESET_HOLD);
        step_and_check(16'h0001);   // Dropped while held
        value_write(debug_pkg::VAL_PC, rand_word());
        check_value(debug_pkg::VAL_PC);
        value_write(debug_pkg::VAL_RESET_HOLD, 16'h0000);
        for (int i = 0; i < 3; i++)
        begin
            step_and_check(16'h0001);
        end

        // Aborted frames leave memory and PC untouched
        addr = rand_word();
        push_header(debug_pkg::CMD_MEM_WRITE, addr);
        void'(tx_bytes.pop_back());
        aborted_frame(4);
        mem_read(addr, 4);
        push_header(debug_pkg::CMD_VALUE_WRITE, debug_pkg::VAL_PC);
        tx_bytes.push_back(rand_byte());
        aborted_frame(5);
        check_value(debug_pkg::VAL_PC);

        $display("Checks %0d, mismatches %0d, timeouts %0d",
                 check_count, mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+include
logic/debug_pkg.sv
logic/spi_peripheral.sv
logic/debug_command.sv
logic/debug_memory.sv
logic/debug_values.sv
logic/fetch_sequencer.sv
logic/debugger_top.sv
test/tb_debugger.sv
